// File: rtl/rename_pkg.sv
/* Shared sizes and tag types for the rename and retire core.
   Imported by every RTL block and by the testbench. */
`default_nettype none

package rename_pkg;

	localparam int AR_COUNT  = 32;                  // Architectural registers
	localparam int PR_COUNT  = 40;                  // Physical registers
	localparam int ROB_DEPTH = 8;                   // Reorder buffer slots
	localparam int FL_DEPTH  = PR_COUNT - AR_COUNT; // Tags free after reset

	// Architectural register index
	typedef logic [$clog2(AR_COUNT)-1:0] ar_tag_t;

	// Physical register tag
	typedef logic [$clog2(PR_COUNT)-1:0] pr_tag_t;

	// Reorder buffer slot index
	typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

	// Reorder buffer occupancy, 0 to ROB_DEPTH
	typedef logic [$clog2(ROB_DEPTH):0] rob_count_t;

	// Free list slot index
	typedef logic [$clog2(FL_DEPTH)-1:0] fl_idx_t;

	// Free list occupancy, 0 to FL_DEPTH
	typedef logic [$clog2(FL_DEPTH+1)-1:0] fl_count_t;

endpackage

`default_nettype wire

// File: rtl/rename_if.sv
/* One dispatch allocation as seen by the reorder buffer, map table
   and free list. Instantiated once inside the rename core. */
`timescale 1ns/1ps
`default_nettype none

interface rename_if
	import rename_pkg::*;
();

	logic     alloc;   // Instruction accepted this cycle
	ar_tag_t  dest_ar; // Destination register of that instruction
	pr_tag_t  new_pr;  // Free list head
	pr_tag_t  told_pr; // Previous mapping of dest_ar
	rob_idx_t rob_idx; // Slot being written

	modport rob (output alloc, dest_ar, rob_idx, input new_pr, told_pr);

	modport map_table (input alloc, dest_ar, new_pr, output told_pr);

	modport free_list (input alloc, output new_pr);

endinterface

`default_nettype wire

// File: rtl/map_table.sv
/* Architectural to physical register map with per-tag ready bits.
   Renames both sources combinationally and records each new destination. */
`timescale 1ns/1ps
`default_nettype none

module map_table
	import rename_pkg::*;
(
	input  logic         clock,
	input  logic         rst_n,
	rename_if.map_table  rn,
	input  ar_tag_t      src_a_ar,
	input  ar_tag_t      src_b_ar,
	input  logic         cdb_valid,
	input  pr_tag_t      cdb_pr,
	output pr_tag_t      src_a_pr,
	output pr_tag_t      src_b_pr,
	output logic         src_a_ready,
	output logic         src_b_ready
);

	pr_tag_t             map_q [AR_COUNT]; // Current mapping per register
	logic [PR_COUNT-1:0] ready_q;          // Value available per tag

	// Ready bit with a same-cycle completion folded in
	function automatic logic tag_ready(input pr_tag_t tag);
		return ready_q[tag] | (cdb_valid && (cdb_pr == tag));
	endfunction

	// Lookups see the table before this cycle's destination write
	assign src_a_pr   = map_q[src_a_ar];
	assign src_b_pr   = map_q[src_b_ar];
	assign rn.told_pr = map_q[rn.dest_ar]; // Old tag, freed at retire

	assign src_a_ready = tag_ready(src_a_pr);
	assign src_b_ready = tag_ready(src_b_pr);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < AR_COUNT; i++) begin
				map_q[i] <= pr_tag_t'(i); // Identity mapping
			end
			ready_q <= '1;
		end else begin
			if (cdb_valid) begin
				ready_q[cdb_pr] <= 1'b1;
			end
			if (rn.alloc) begin
				map_q[rn.dest_ar]  <= rn.new_pr;
				ready_q[rn.new_pr] <= 1'b0; // Producer not done yet
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/free_list.sv
/* Circular queue of free physical tags. The head is handed out at
   dispatch and retired old tags are appended at the tail. */
`timescale 1ns/1ps
`default_nettype none

module free_list
	import rename_pkg::*;
(
	input  logic         clock,
	input  logic         rst_n,
	rename_if.free_list  rn,
	input  logic         retire_valid,
	input  pr_tag_t      retire_told,
	output logic         fl_empty
);

	pr_tag_t   tags_q [FL_DEPTH]; // Queue storage
	fl_idx_t   head;              // Next tag to hand out
	fl_idx_t   tail;              // Next free position
	fl_count_t count;             // Tags currently held

	assign rn.new_pr = tags_q[head];
	assign fl_empty  = (count == '0);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < FL_DEPTH; i++) begin
				tags_q[i] <= pr_tag_t'(AR_COUNT + i); // Tags 32 to 39
			end
			head  <= '0;
			tail  <= '0;
			count <= fl_count_t'(FL_DEPTH);
		end else begin
			if (rn.alloc) begin
				head <= head + fl_idx_t'(1);
			end
			if (retire_valid) begin
				tags_q[tail] <= retire_told;
				tail         <= tail + fl_idx_t'(1);
			end
			// Pop and push together leave the count alone
			count <= count + fl_count_t'(retire_valid) - fl_count_t'(rn.alloc);
		end
	end

endmodule

`default_nettype wire

// File: rtl/rob.sv
/* Reorder buffer. Decides dispatch stall, allocates slots in program
   order, marks completions and retires the done head one slot at a time. */
`timescale 1ns/1ps
`default_nettype none

module rob
	import rename_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,
	rename_if.rob     rn,
	input  logic      dispatch_valid,
	input  ar_tag_t   dispatch_dest_ar,
	input  logic      fl_empty,
	input  logic      complete_valid,
	input  rob_idx_t  complete_rob_idx,
	output logic      dispatch_stall,
	output logic      cdb_valid,
	output pr_tag_t   cdb_pr,
	output logic      retire_valid,
	output ar_tag_t   retire_ar,
	output pr_tag_t   retire_pr,
	output pr_tag_t   retire_told
);

	ar_tag_t              slot_ar   [ROB_DEPTH]; // Destination register
	pr_tag_t              slot_pr   [ROB_DEPTH]; // Newly mapped tag
	pr_tag_t              slot_told [ROB_DEPTH]; // Tag it replaced
	logic [ROB_DEPTH-1:0] slot_done;

	rob_idx_t   head;
	rob_idx_t   tail;
	rob_count_t count;

	rob_idx_t   head_nxt;
	rob_count_t live_nxt;
	logic       head_nxt_done;
	logic       full;

	assign full           = (count == rob_count_t'(ROB_DEPTH));
	assign dispatch_stall = full | fl_empty;

	assign rn.alloc   = dispatch_valid & ~dispatch_stall;
	assign rn.dest_ar = dispatch_dest_ar;
	assign rn.rob_idx = tail;

	// Completion broadcast goes to the map table ready bits
	assign cdb_valid = complete_valid;
	assign cdb_pr    = slot_pr[complete_rob_idx];

	// Head stays on the retiring slot until the pulse ends
	assign retire_ar   = slot_ar[head];
	assign retire_pr   = slot_pr[head];
	assign retire_told = slot_told[head];

	/* The retire pulse is registered, so it is decided one edge early
	   from the head and occupancy that remain after the current pulse. */
	assign head_nxt      = head + rob_idx_t'(retire_valid);
	assign live_nxt      = count - rob_count_t'(retire_valid);
	assign head_nxt_done = slot_done[head_nxt] |
	                       (complete_valid && (complete_rob_idx == head_nxt));

	always_ff @(posedge clock) begin
		if (rn.alloc) begin
			slot_ar[tail]   <= rn.dest_ar;
			slot_pr[tail]   <= rn.new_pr;
			slot_told[tail] <= rn.told_pr;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			slot_done    <= '0;
			retire_valid <= 1'b0;
		end else begin
			if (complete_valid) begin
				slot_done[complete_rob_idx] <= 1'b1;
			end
			if (rn.alloc) begin
				slot_done[tail] <= 1'b0; // Fresh slot starts pending
				tail            <= tail + rob_idx_t'(1);
			end
			head         <= head_nxt;
			count        <= live_nxt + rob_count_t'(rn.alloc);
			retire_valid <= (live_nxt != '0) && head_nxt_done; // Oldest is done
		end
	end

endmodule

`default_nettype wire

// File: rtl/rename_core.sv
/* Rename and in-order retire core. Connects the map table, free list
   and reorder buffer; dispatch, completion and retire use plain ports. */
`timescale 1ns/1ps
`default_nettype none

module rename_core
	import rename_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,
	input  logic      dispatch_valid,
	input  ar_tag_t   dispatch_dest_ar,
	input  ar_tag_t   dispatch_src_a_ar,
	input  ar_tag_t   dispatch_src_b_ar,
	input  logic      complete_valid,
	input  rob_idx_t  complete_rob_idx,
	output logic      dispatch_stall,
	output pr_tag_t   src_a_pr,
	output pr_tag_t   src_b_pr,
	output logic      src_a_ready,
	output logic      src_b_ready,
	output pr_tag_t   dest_pr,
	output rob_idx_t  dest_rob_idx,
	output logic      retire_valid,
	output ar_tag_t   retire_ar,
	output pr_tag_t   retire_pr,
	output pr_tag_t   retire_told
);

	rename_if rn ();

	logic    fl_empty;
	logic    cdb_valid;
	pr_tag_t cdb_pr;

	assign dest_pr      = rn.new_pr;
	assign dest_rob_idx = rn.rob_idx;

	map_table u_map_table (
		.clock       (clock),
		.rst_n       (rst_n),
		.rn          (rn.map_table),
		.src_a_ar    (dispatch_src_a_ar),
		.src_b_ar    (dispatch_src_b_ar),
		.cdb_valid   (cdb_valid),
		.cdb_pr      (cdb_pr),
		.src_a_pr    (src_a_pr),
		.src_b_pr    (src_b_pr),
		.src_a_ready (src_a_ready),
		.src_b_ready (src_b_ready)
	);

	free_list u_free_list (
		.clock        (clock),
		.rst_n        (rst_n),
		.rn           (rn.free_list),
		.retire_valid (retire_valid),
		.retire_told  (retire_told), // Old tag comes back here
		.fl_empty     (fl_empty)
	);

	rob u_rob (
		.clock            (clock),
		.rst_n            (rst_n),
		.rn               (rn.rob),
		.dispatch_valid   (dispatch_valid),
		.dispatch_dest_ar (dispatch_dest_ar),
		.fl_empty         (fl_empty),
		.complete_valid   (complete_valid),
		.complete_rob_idx (complete_rob_idx),
		.dispatch_stall   (dispatch_stall),
		.cdb_valid        (cdb_valid),
		.cdb_pr           (cdb_pr),
		.retire_valid     (retire_valid),
		.retire_ar        (retire_ar),
		.retire_pr        (retire_pr),
		.retire_told      (retire_told)
	);

endmodule

`default_nettype wire

// File: verification/rename_asserts.sv
/* Assertions on dispatch and retirement, bound into every rob instance. */
`timescale 1ns/1ps
`default_nettype none

module rename_asserts
	import rename_pkg::*;
(
	input logic       clock,
	input logic       rst_n,
	input logic       dispatch_stall,
	input logic       retire_valid,
	input rob_idx_t   tail,
	input rob_count_t count
);

	// A stalled cycle allocates no slot
	no_alloc_on_stall: assert property (@(posedge clock) disable iff (!rst_n)
		dispatch_stall |=> $stable(tail))
		else $error("reorder buffer tail moved after a stalled cycle");

	retire_needs_entry: assert property (@(posedge clock) disable iff (!rst_n)
		retire_valid |-> (count != '0))
		else $error("retire_valid with an empty reorder buffer");

	// Empty buffer and full free list right after reset
	open_after_reset: assert property (@(posedge clock) $rose(rst_n) |-> !dispatch_stall)
		else $error("dispatch_stall high in the first cycle after reset");

endmodule

bind rob rename_asserts u_rob_asserts (
	.clock          (clock),
	.rst_n          (rst_n),
	.dispatch_stall (dispatch_stall),
	.retire_valid   (retire_valid),
	.tail           (tail),
	.count          (count)
);

`default_nettype wire

// File: verification/rename_tb.sv
/* Testbench for the rename core. Steps a stimulus table through the DUT and
   compares every cycle with a reference model of the map, free list and ROB. */
`timescale 1ns/1ps
`default_nettype none

module rename_tb
	import rename_pkg::*;
();

	localparam int CLK_PERIOD      = 10;
	localparam int RST_CYCLES      = 8;
	localparam int ROWS            = 30;
	localparam int WATCHDOG_CYCLES = ROWS * 20 + RST_CYCLES;

	typedef struct {
		int dv, dest, sa, sb; // Dispatch valid and registers
		int cv, cord;         // Completion valid and target ordinal
	} row_t;

	logic     clock;
	logic     rst_n;
	logic     dispatch_valid;
	ar_tag_t  dispatch_dest_ar;
	ar_tag_t  dispatch_src_a_ar;
	ar_tag_t  dispatch_src_b_ar;
	logic     complete_valid;
	rob_idx_t complete_rob_idx;
	logic     dispatch_stall;
	pr_tag_t  src_a_pr;
	pr_tag_t  src_b_pr;
	logic     src_a_ready;
	logic     src_b_ready;
	pr_tag_t  dest_pr;
	rob_idx_t dest_rob_idx;
	logic     retire_valid;
	ar_tag_t  retire_ar;
	pr_tag_t  retire_pr;
	pr_tag_t  retire_told;

	row_t rows [ROWS];
	int   row_count;
	int   errors;

	int map_m [AR_COUNT];  // Reference mapping
	bit ready_m [PR_COUNT];
	int free_q [$];        // Free tags, head first
	int inflight [$];      // Ordinals not yet retired
	int ord_ar [ROWS];
	int ord_pr [ROWS];
	int ord_told [ROWS];
	int ord_idx [ROWS];    // ROB slot the DUT gave each dispatch
	bit ord_done [ROWS];
	int accepted;
	bit exp_retire;        // Retire pulse expected this cycle

	rename_core DUT (.*);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the DUT did not get through the stimulus table in time");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

	function automatic void add_row(int dv, int dest, int sa, int sb, int cv, int cord);
		rows[row_count] = '{dv, dest, sa, sb, cv, cord};
		row_count++;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			errors++;
			$display("FAIL @ %0t ns: %s is %0d, expected %0d", $time, what, got, want);
			$display("Test failures found");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	// Ready as the map table should report it, same-cycle completion included
	function automatic bit ready_exp(int tag, row_t r);
		return ready_m[tag] || (r.cv != 0 && ord_pr[r.cord] == tag);
	endfunction

	task automatic check_outputs(input row_t r, input bit stall_exp, input bit accept);
		int h;
		check(32'(dispatch_stall), 32'(stall_exp), "dispatch_stall");
		check(32'(src_a_pr), map_m[r.sa], "src_a_pr");
		check(32'(src_b_pr), map_m[r.sb], "src_b_pr");
		check(32'(src_a_ready), 32'(ready_exp(map_m[r.sa], r)), "src_a_ready");
		check(32'(src_b_ready), 32'(ready_exp(map_m[r.sb], r)), "src_b_ready");
		if (accept) begin
			check(32'(dest_pr), free_q[0], "dest_pr");
			check(32'(dest_rob_idx), accepted % ROB_DEPTH, "dest_rob_idx");
		end
		check(32'(retire_valid), 32'(exp_retire), "retire_valid");
		if (exp_retire) begin
			h = inflight[0];
			check(32'(retire_ar), ord_ar[h], "retire_ar");
			check(32'(retire_pr), ord_pr[h], "retire_pr");
			check(32'(retire_told), ord_told[h], "retire_told");
		end
	endtask

	// Advances the model across the coming clock edge
	task automatic model_step(input row_t r, input bit accept);
		int h;
		if (r.cv != 0) begin
			ord_done[r.cord]        = 1'b1;
			ready_m[ord_pr[r.cord]] = 1'b1;
		end
		if (exp_retire) begin
			h = inflight.pop_front();
			free_q.push_back(ord_told[h]); // Old tag back to the tail
		end
		if (accept) begin
			ord_ar[accepted]          = r.dest;
			ord_pr[accepted]          = free_q.pop_front();
			ord_told[accepted]        = map_m[r.dest];
			ord_idx[accepted]         = int'(dest_rob_idx);
			ready_m[ord_pr[accepted]] = 1'b0;
			map_m[r.dest]             = ord_pr[accepted];
			inflight.push_back(accepted);
			accepted++;
		end
		exp_retire = 1'b0;
		if (inflight.size() > 0) begin
			exp_retire = ord_done[inflight[0]]; // Done head retires next cycle
		end
	endtask

	task automatic fill_table();
		// Columns: dispatch valid, dest, src a, src b, complete valid, ordinal
		add_row(0, 0, 1, 31, 0, 0);   // Identity mapping after reset
		add_row(1, 5, 5, 6, 0, 0);    // Source equal to dest sees old tag
		add_row(1, 7, 5, 7, 0, 0);
		add_row(1, 5, 5, 1, 0, 0);
		add_row(1, 9, 5, 7, 1, 2);    // Bypass on completing producer
		add_row(0, 0, 7, 9, 1, 1);    // Completions out of order
		add_row(0, 0, 5, 9, 1, 0);
		add_row(0, 0, 5, 9, 1, 3);
		add_row(0, 0, 5, 7, 0, 0);
		add_row(0, 0, 9, 5, 0, 0);
		add_row(0, 0, 9, 7, 0, 0);
		add_row(1, 1, 1, 2, 0, 0);    // Fill all eight slots
		add_row(1, 2, 1, 3, 0, 0);
		add_row(1, 3, 2, 4, 0, 0);
		add_row(1, 4, 3, 5, 0, 0);
		add_row(1, 10, 4, 9, 0, 0);
		add_row(1, 11, 10, 7, 0, 0);
		add_row(1, 12, 11, 12, 0, 0);
		add_row(1, 13, 12, 13, 0, 0);
		add_row(1, 20, 1, 2, 0, 0);   // Stalled, nothing may change
		add_row(1, 20, 1, 13, 1, 4);
		add_row(1, 21, 1, 2, 0, 0);
		add_row(1, 22, 22, 1, 0, 0);  // Retired tag handed out again
		add_row(1, 23, 22, 2, 1, 6);
		add_row(0, 0, 2, 3, 1, 5);
		add_row(0, 0, 2, 3, 0, 0);
		add_row(1, 24, 22, 1, 0, 0);
		add_row(1, 25, 24, 22, 0, 0);
		add_row(0, 0, 22, 24, 1, 12);
		add_row(0, 0, 22, 25, 0, 0);
	endtask

	initial begin
		bit stall_exp;
		bit accept;
		rst_n             = 1'b0;
		dispatch_valid    = 1'b0;
		dispatch_dest_ar  = '0;
		dispatch_src_a_ar = '0;
		dispatch_src_b_ar = '0;
		complete_valid    = 1'b0;
		complete_rob_idx  = '0;
		errors            = 0;
		row_count         = 0;
		accepted          = 0;
		exp_retire        = 1'b0;
		for (int i = 0; i < AR_COUNT; i++) begin
			map_m[i] = i;
		end
		for (int i = 0; i < PR_COUNT; i++) begin
			ready_m[i] = 1'b1;
		end
		for (int i = AR_COUNT; i < PR_COUNT; i++) begin
			free_q.push_back(i);
		end
		fill_table();
		repeat (RST_CYCLES) @(posedge clock);
		rst_n <= 1'b1;
		for (int i = 0; i < ROWS; i++) begin
			@(posedge clock);
			dispatch_valid    <= (rows[i].dv != 0);
			dispatch_dest_ar  <= ar_tag_t'(rows[i].dest);
			dispatch_src_a_ar <= ar_tag_t'(rows[i].sa);
			dispatch_src_b_ar <= ar_tag_t'(rows[i].sb);
			complete_valid    <= (rows[i].cv != 0);
			complete_rob_idx  <= rob_idx_t'(ord_idx[rows[i].cord]);
			@(negedge clock); // Combinational outputs settled
			stall_exp = (inflight.size() == ROB_DEPTH) || (free_q.size() == 0);
			accept    = (rows[i].dv != 0) && !stall_exp;
			check_outputs(rows[i], stall_exp, accept);
			model_step(rows[i], accept);
		end
		@(posedge clock);
		dispatch_valid <= 1'b0;
		complete_valid <= 1'b0;
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
rtl/rename_pkg.sv
rtl/rename_if.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/rob.sv
rtl/rename_core.sv
verification/rename_asserts.sv
verification/rename_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the rename core testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -j 0 --top-module rename_tb -f build.f

# An assertion may stop the simulator early, the log is checked below
./obj_dir/Vrename_tb 2>&1 | tee "$LOG" || true

if grep -q "Test failures found" "$LOG" || grep -q "%Error" "$LOG" \
	|| ! grep -q "All tests passed!" "$LOG"; then
	echo "Simulation FAILED, see $LOG"
	exit 1
fi
echo "Simulation passed"
